// File: filelist.f
+incdir+logic
logic/vtx_pkg.sv
logic/dp_ram.sv
logic/axil_regs.sv
logic/tx_memory_control.sv
logic/byte_stream.sv
logic/frame_tx_top.sv
tests/frame_tx_assert.sv
tests/frame_tx_checker.sv
tests/frame_tx_tb.sv

// File: logic/axil_regs.sv
// AXI4-Lite full-word writes only (no wstrb), responses always OKAY, start write dropped while busy
`timescale 1ns/100ps
`include "vtx_config.svh"

module axil_regs (
	input  logic                            clk125MHz,
	input  logic                            rst_n,
	input  logic [`VTX_AXI_AW-1:0]          s_axil_awaddr,
	input  logic                            s_axil_awvalid,
	output logic                            s_axil_awready,
	input  logic [31:0]                     s_axil_wdata,
	input  logic                            s_axil_wvalid,
	output logic                            s_axil_wready,
	output logic [1:0]                      s_axil_bresp,
	output logic                            s_axil_bvalid,
	input  logic                            s_axil_bready,
	input  logic [`VTX_AXI_AW-1:0]          s_axil_araddr,
	input  logic                            s_axil_arvalid,
	output logic                            s_axil_arready,
	output logic [31:0]                     s_axil_rdata,
	output logic [1:0]                      s_axil_rresp,
	output logic                            s_axil_rvalid,
	input  logic                            s_axil_rready,
	input  logic [23:0]                     startaddr,
	input  logic                            busy,
	output logic                            start,
	output logic [7:0]                      txid,
	output logic [$clog2(`VTX_SEG_MAX)-1:0] segment,
	output logic [7:0]                      redundancy,
	output logic [23:0]                     lastaddr
);

	logic                   bus_up; // readies held low right after reset
	logic                   aw_held;
	logic                   w_held;
	logic [`VTX_AXI_AW-1:0] aw_addr_q;
	logic [31:0]            w_data_q;
	logic                   aw_fire;
	logic                   w_fire;
	logic                   ar_fire;
	logic                   wr_go;
	logic [`VTX_AXI_AW-1:0] wr_addr;
	logic [31:0]            wr_data;
	logic [31:0]            rd_mux;

	assign s_axil_awready = bus_up && !aw_held;
	assign s_axil_wready  = bus_up && !w_held;
	assign s_axil_arready = bus_up && !s_axil_rvalid;
	assign s_axil_bresp   = 2'b00;
	assign s_axil_rresp   = 2'b00;

	assign aw_fire = s_axil_awvalid && s_axil_awready;
	assign w_fire  = s_axil_wvalid && s_axil_wready;
	assign ar_fire = s_axil_arvalid && s_axil_arready;

	// take each channel either from the bus or from its latch
	assign wr_addr = aw_held ? aw_addr_q : s_axil_awaddr;
	assign wr_data = w_held ? w_data_q : s_axil_wdata;
	assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire) && !s_axil_bvalid;

	// ========================================
	// write channel
	// ========================================
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			bus_up        <= 1'b0;
			aw_held       <= 1'b0;
			w_held        <= 1'b0;
			s_axil_bvalid <= 1'b0;
		end else begin
			bus_up <= 1'b1;
			if (wr_go) begin
				aw_held <= 1'b0;
				w_held  <= 1'b0;
			end else begin
				if (aw_fire) aw_held <= 1'b1; // wait for the other half
				if (w_fire) w_held <= 1'b1;
			end
			if (wr_go) begin
				s_axil_bvalid <= 1'b1;
			end else if (s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (aw_fire) aw_addr_q <= s_axil_awaddr;
		if (w_fire) w_data_q <= s_axil_wdata;
	end

	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			start      <= 1'b0;
			txid       <= '0;
			segment    <= '0;
			redundancy <= '0;
			lastaddr   <= '0;
		end else begin
			start <= 1'b0; // single-cycle pulse
			if (wr_go) begin
				case (wr_addr)
					`VTX_REG_CTRL:       start <= wr_data[0] && !busy;
					`VTX_REG_TXID:       txid <= wr_data[7:0];
					`VTX_REG_SEGMENT:    segment <= wr_data[$bits(segment)-1:0];
					`VTX_REG_REDUNDANCY: redundancy <= wr_data[7:0];
					`VTX_REG_LASTADDR:   lastaddr <= wr_data[23:0];
					default:             ; // read-only and unmapped offsets
				endcase
			end
		end
	end

	// ========================================
	// read channel
	// ========================================
	always_comb begin
		rd_mux = '0;
		case (s_axil_araddr)
			`VTX_REG_TXID:       rd_mux[7:0] = txid;
			`VTX_REG_SEGMENT:    rd_mux[$bits(segment)-1:0] = segment;
			`VTX_REG_REDUNDANCY: rd_mux[7:0] = redundancy;
			`VTX_REG_LASTADDR:   rd_mux[23:0] = lastaddr;
			`VTX_REG_STARTADDR:  rd_mux[23:0] = startaddr;
			`VTX_REG_STATUS:     rd_mux[0] = busy;
			default:             rd_mux = '0; // CTRL reads as zero
		endcase
	end

	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			s_axil_rvalid <= 1'b0;
		end else if (ar_fire) begin
			s_axil_rvalid <= 1'b1;
		end else if (s_axil_rready) begin
			s_axil_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (ar_fire) s_axil_rdata <= rd_mux;
	end

endmodule

// File: logic/byte_stream.sv
// two-entry output buffer, an issue is only legal if credit was nonzero the cycle before
`timescale 1ns/100ps

module byte_stream (
	input  logic           clk125MHz,
	input  logic           rst_n,
	input  logic           issue,
	input  logic           issue_last,
	input  vtx_pkg::byte_t byte_in,
	input  logic           tx_ready,
	output logic           tx_valid,
	output vtx_pkg::byte_t tx_data,
	output logic           tx_last,
	output logic [1:0]     credit,
	output logic           last_accepted
);
	import vtx_pkg::*;

	byte_t      data_q [2];
	logic [1:0] last_q;
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;  // entries held
	logic       pop;

	assign tx_valid      = (count != 2'd0);
	assign tx_data       = data_q[rd_ptr];
	assign tx_last       = tx_valid && last_q[rd_ptr];
	assign pop           = tx_valid && tx_ready;
	assign last_accepted = pop && tx_last;

	// free entries, minus the byte landing now, plus the one leaving now
	assign credit = 2'd2 - count - {1'b0, issue} + {1'b0, pop};

	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (issue) wr_ptr <= !wr_ptr;
			if (pop) rd_ptr <= !rd_ptr;
			count <= count + {1'b0, issue} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (issue) begin
			data_q[wr_ptr] <= byte_in;
			last_q[wr_ptr] <= issue_last;
		end
	end

endmodule

// File: logic/dp_ram.sv
// one write port and one registered read port, a read of the address being written returns old data
`timescale 1ns/100ps

module dp_ram #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 64
) (
	input  logic                     clk125MHz,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  payload_t                 wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output payload_t                 rdata
);

	payload_t mem [DEPTH];

	always_ff @(posedge clk125MHz) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	always_ff @(posedge clk125MHz) begin
		rdata <= mem[raddr]; // data valid one cycle after raddr
	end

endmodule

// File: logic/frame_tx_top.sv
// pixels must already be synchronous to clk125MHz, no Ethernet framing is added to the stream
`timescale 1ns/100ps
`include "vtx_config.svh"

module frame_tx_top (
	input  logic                   clk125MHz,
	input  logic                   rst_n,
	input  logic [`VTX_AXI_AW-1:0] s_axil_awaddr,
	input  logic                   s_axil_awvalid,
	output logic                   s_axil_awready,
	input  logic [31:0]            s_axil_wdata,
	input  logic                   s_axil_wvalid,
	output logic                   s_axil_wready,
	output logic [1:0]             s_axil_bresp,
	output logic                   s_axil_bvalid,
	input  logic                   s_axil_bready,
	input  logic [`VTX_AXI_AW-1:0] s_axil_araddr,
	input  logic                   s_axil_arvalid,
	output logic                   s_axil_arready,
	output logic [31:0]            s_axil_rdata,
	output logic [1:0]             s_axil_rresp,
	output logic                   s_axil_rvalid,
	input  logic                   s_axil_rready,
	input  logic                   pix_we,
	input  vtx_pkg::pix_addr_t     pix_addr,
	input  vtx_pkg::pixel_t        pix_data,
	input  logic                   data_user,
	output logic                   tx_valid,
	output vtx_pkg::byte_t         tx_data,
	output logic                   tx_last,
	input  logic                   tx_ready
);
	import vtx_pkg::*;

	logic                            start;
	logic [7:0]                      txid;
	logic [$clog2(`VTX_SEG_MAX)-1:0] segment;
	logic [7:0]                      redundancy;
	logic [23:0]                     lastaddr;
	logic [23:0]                     startaddr;
	logic                            busy;
	pix_addr_t                       vram_raddr;
	pixel_t                          vram_rdata;
	seg_addr_t                       store_raddr;
	byte_t                           store_rdata;
	logic                            store_we;
	seg_addr_t                       store_waddr;
	byte_t                           store_wdata;
	logic                            issue;
	logic                            issue_last;
	byte_t                           byte_out;
	logic [1:0]                      credit;
	logic                            last_accepted;

	axil_regs u_regs (
		.clk125MHz      (clk125MHz),
		.rst_n          (rst_n),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready),
		.startaddr      (startaddr),
		.busy           (busy),
		.start          (start),
		.txid           (txid),
		.segment        (segment),
		.redundancy     (redundancy),
		.lastaddr       (lastaddr)
	);

	tx_memory_control u_ctrl (
		.clk125MHz     (clk125MHz),
		.rst_n         (rst_n),
		.start         (start),
		.txid          (txid),
		.segment       (segment),
		.redundancy    (redundancy),
		.lastaddr      (lastaddr),
		.data_user     (data_user),
		.vram_rdata    (vram_rdata),
		.store_rdata   (store_rdata),
		.credit        (credit),
		.last_accepted (last_accepted),
		.vram_raddr    (vram_raddr),
		.store_raddr   (store_raddr),
		.store_we      (store_we),
		.store_waddr   (store_waddr),
		.store_wdata   (store_wdata),
		.issue         (issue),
		.issue_last    (issue_last),
		.byte_out      (byte_out),
		.busy          (busy),
		.startaddr     (startaddr)
	);

	// captured frame, written straight from the pixel input
	dp_ram #(.payload_t(pixel_t), .DEPTH(`VTX_VRAM_DEPTH)) u_vram (
		.clk125MHz (clk125MHz),
		.we        (pix_we),
		.waddr     (pix_addr),
		.wdata     (pix_data),
		.raddr     (vram_raddr),
		.rdata     (vram_rdata)
	);

	// bytes of the first transmission, by segment and offset
	dp_ram #(.payload_t(byte_t), .DEPTH(`VTX_SEG_MAX * `VTX_SEG_LEN)) u_retx_store (
		.clk125MHz (clk125MHz),
		.we        (store_we),
		.waddr     (store_waddr),
		.wdata     (store_wdata),
		.raddr     (store_raddr),
		.rdata     (store_rdata)
	);

	byte_stream u_stream (
		.clk125MHz     (clk125MHz),
		.rst_n         (rst_n),
		.issue         (issue),
		.issue_last    (issue_last),
		.byte_in       (byte_out),
		.tx_ready      (tx_ready),
		.tx_valid      (tx_valid),
		.tx_data       (tx_data),
		.tx_last       (tx_last),
		.credit        (credit),
		.last_accepted (last_accepted)
	);

endmodule

// File: logic/tx_memory_control.sv
// one segment per start, txid 1 reads VRAM and fills the store, any other txid replays the store
`timescale 1ns/100ps
`include "vtx_config.svh"

module tx_memory_control (
	input  logic                            clk125MHz,
	input  logic                            rst_n,
	input  logic                            start,
	input  logic [7:0]                      txid,
	input  logic [$clog2(`VTX_SEG_MAX)-1:0] segment,
	input  logic [7:0]                      redundancy,
	input  logic [23:0]                     lastaddr,
	input  logic                            data_user,
	input  vtx_pkg::pixel_t                 vram_rdata,
	input  vtx_pkg::byte_t                  store_rdata,
	input  logic [1:0]                      credit,
	input  logic                            last_accepted,
	output vtx_pkg::pix_addr_t              vram_raddr,
	output vtx_pkg::seg_addr_t              store_raddr,
	output logic                            store_we,
	output vtx_pkg::seg_addr_t              store_waddr,
	output vtx_pkg::byte_t                  store_wdata,
	output logic                            issue,
	output logic                            issue_last,
	output vtx_pkg::byte_t                  byte_out,
	output logic                            busy,
	output logic [23:0]                     startaddr
);
	import vtx_pkg::*;

	localparam int CNT_W = $clog2(`VTX_SEG_LEN);

	logic             issuing;    // reads still to be issued
	logic             first_tx;   // latched txid == 1
	logic [CNT_W-1:0] byte_cnt;
	seg_addr_t        addr_cnt;
	pix_addr_t        pix_cnt;
	color_sel_t       col;
	seg_addr_t        start_byte;
	seg_addr_t        start_mod;
	logic             req;
	logic             req_last;
	color_sel_t       col_d;      // lines up with RAM data
	seg_addr_t        addr_d;
	byte_t            vram_byte;
	logic [1:0]       du_sync;

	assign start_byte  = {segment, {CNT_W{1'b0}}};
	assign start_mod   = start_byte % seg_addr_t'(3);
	assign req         = issuing && (credit != 2'd0);
	assign req_last    = req && (&byte_cnt); // 16th byte
	assign vram_raddr  = pix_cnt;
	assign store_raddr = addr_cnt;

	// ========================================
	// segment sequencer
	// ========================================
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			issuing    <= 1'b0;
			first_tx   <= 1'b0;
			byte_cnt   <= '0;
			addr_cnt   <= '0;
			pix_cnt    <= '0;
			col        <= COL_R;
			issue      <= 1'b0;
			issue_last <= 1'b0;
		end else begin
			issue      <= req;      // RAM data follows one cycle later
			issue_last <= req_last;
			if (start && !busy) begin
				busy     <= 1'b1;
				issuing  <= 1'b1;
				first_tx <= (txid == 8'd1);
				byte_cnt <= '0;
				addr_cnt <= start_byte;
				pix_cnt  <= pix_addr_t'(start_byte / seg_addr_t'(3));
				col      <= color_sel_t'(start_mod[1:0]);
			end else begin
				if (last_accepted) busy <= 1'b0;
				if (req) begin
					byte_cnt <= byte_cnt + 1'b1;
					addr_cnt <= addr_cnt + 1'b1;
					if (req_last) issuing <= 1'b0;
					case (col)
						COL_B: begin
							col     <= COL_R;
							pix_cnt <= pix_cnt + 1'b1; // next pixel after blue
						end
						COL_G:   col <= COL_B;
						default: col <= COL_G;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (req) begin
			col_d  <= col;
			addr_d <= addr_cnt;
		end
	end

	// ========================================
	// byte source and store fill
	// ========================================
	always_comb begin
		case (col_d)
			COL_R:   vram_byte = vram_rdata.r;
			COL_G:   vram_byte = vram_rdata.g;
			default: vram_byte = vram_rdata.b;
		endcase
	end

	assign byte_out    = first_tx ? vram_byte : store_rdata;
	assign store_we    = issue && first_tx; // copy only on the first transmission
	assign store_waddr = addr_d;
	assign store_wdata = vram_byte;

	// data_user falling edge loads startaddr when txid matches redundancy
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			du_sync   <= 2'b00;
			startaddr <= '0;
		end else begin
			du_sync <= {du_sync[0], data_user};
			if ((du_sync == 2'b10) && (txid == redundancy)) begin
				startaddr <= lastaddr;
			end
		end
	end

endmodule

// File: logic/vtx_config.svh
// sizes must stay powers of two, segment bytes are assumed to fit inside the VRAM
`ifndef VTX_CONFIG_SVH
`define VTX_CONFIG_SVH

`define VTX_VRAM_DEPTH 64 // pixels held in the VRAM
`define VTX_SEG_LEN    16 // bytes per segment
`define VTX_SEG_MAX    4  // segments per frame
`define VTX_AXI_AW     8  // AXI4-Lite address bits

// ========================================
// register offsets
// ========================================
`define VTX_REG_CTRL       8'h00 // bit0 start pulse
`define VTX_REG_TXID       8'h04
`define VTX_REG_SEGMENT    8'h08
`define VTX_REG_REDUNDANCY 8'h0C
`define VTX_REG_LASTADDR   8'h10
`define VTX_REG_STARTADDR  8'h14 // read only
`define VTX_REG_STATUS     8'h18 // bit0 busy

`endif

// File: logic/vtx_pkg.sv
// all widths follow the config header, seg_addr_t packs segment above offset
`include "vtx_config.svh"

package vtx_pkg;

	typedef logic [7:0] byte_t;

	// one captured RGB pixel, red in the top byte
	typedef struct packed {
		byte_t r;
		byte_t g;
		byte_t b;
	} pixel_t;

	typedef logic [$clog2(`VTX_VRAM_DEPTH)-1:0] pix_addr_t;
	typedef logic [$clog2(`VTX_SEG_MAX * `VTX_SEG_LEN)-1:0] seg_addr_t; // {segment, offset}

	// colour of byte n is n % 3
	typedef enum logic [1:0] {
		COL_R = 2'd0,
		COL_G = 2'd1,
		COL_B = 2'd2
	} color_sel_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status follows the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module frame_tx_tb -o frame_tx_sim

out=$(./obj_dir/frame_tx_sim)
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
	exit 0
else
	exit 1
fi

// File: tests/frame_tx_assert.sv
// bound twice, once on the byte stream and once on the AXI slave, unused inputs tied low
`timescale 1ns/100ps

module frame_tx_assert (
	input logic       clk125MHz,
	input logic       rst_n,
	input logic       valid,
	input logic [7:0] data,
	input logic       last,
	input logic       ready,
	input logic       bvalid,
	input logic       bready
);

	int fail_cnt = 0; // failed assertions so far

	a_stream_hold: assert property (@(posedge clk125MHz) disable iff (!rst_n)
		valid && !ready |=> valid && $stable(data))
		else begin
			fail_cnt++;
			$error("stream byte dropped or changed while waiting for ready");
		end

	a_last_hold: assert property (@(posedge clk125MHz) disable iff (!rst_n)
		valid && !ready |=> $stable(last))
		else begin
			fail_cnt++;
			$error("tx_last changed while waiting for ready");
		end

	a_bvalid_hold: assert property (@(posedge clk125MHz) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			fail_cnt++;
			$error("bvalid dropped before bready");
		end

endmodule

// File: tests/frame_tx_checker.sv
// models VRAM and store from the pixel input alone, seg and first must be set before each start
`timescale 1ns/100ps
`include "vtx_config.svh"

module frame_tx_checker (
	input logic               clk125MHz,
	input logic               rst_n,
	input logic               pix_we,
	input vtx_pkg::pix_addr_t pix_addr,
	input vtx_pkg::pixel_t    pix_data,
	input logic               tx_valid,
	input vtx_pkg::byte_t     tx_data,
	input logic               tx_last,
	input logic               tx_ready,
	input logic [1:0]         seg,
	input logic               first,
	input logic               arm,
	output int                nbytes,
	output int                errors
);
	import vtx_pkg::*;

	pixel_t pix_model [`VTX_VRAM_DEPTH];
	byte_t  store_model [`VTX_SEG_MAX * `VTX_SEG_LEN];
	int     idx;
	byte_t  want;

	function automatic byte_t colour_of(input pixel_t p, input int c);
		case (c)
			0:       return p.r;
			1:       return p.g;
			default: return p.b;
		endcase
	endfunction

	task automatic check_value(input string what, input int got, input int expect_val);
		if (got != expect_val) begin
			$display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expect_val);
			errors++;
		end
	endtask

	initial begin
		nbytes = 0;
		errors = 0;
	end

	always @(posedge clk125MHz) begin
		if (pix_we) pix_model[pix_addr] = pix_data;
		if (arm) begin
			nbytes = 0; // new segment starts
		end else if (rst_n && tx_valid && tx_ready) begin
			if (nbytes >= `VTX_SEG_LEN) begin
				$display("extra byte 0x%02h streamed after the segment ended, at %0t", tx_data, $time);
				errors++;
			end else begin
				idx = int'(seg) * `VTX_SEG_LEN + nbytes;
				if (first) begin
					want = colour_of(pix_model[idx / 3], idx % 3);
					store_model[idx] = want; // first transmission fills the store
				end else begin
					want = store_model[idx];
				end
				check_value($sformatf("byte %0d of segment %0d", nbytes, seg), int'(tx_data), int'(want));
				check_value("tx_last", int'(tx_last), int'(nbytes == `VTX_SEG_LEN - 1));
			end
			nbytes++;
		end
	end

endmodule

// File: tests/frame_tx_tb.sv
// single clock at 125 MHz, every AXI and stream wait gives up after a bounded number of cycles
`timescale 1ns/100ps
`include "vtx_config.svh"

module frame_tx_tb;
	import vtx_pkg::*;

	localparam int TIMEOUT  = 200;
	localparam int NUM_ROWS = 10;

	typedef struct {
		int txid;
		int seg;
		int red;
		int last;
		int du;        // 1 gives a data_user falling edge
		int ready_pct;
		int new_pix;   // 1 rewrites the whole VRAM first
	} row_t;

	logic        clk125MHz = 1'b0;
	logic        rst_n;
	logic [7:0]  s_axil_awaddr;
	logic        s_axil_awvalid;
	logic        s_axil_awready;
	logic [31:0] s_axil_wdata;
	logic        s_axil_wvalid;
	logic        s_axil_wready;
	logic [1:0]  s_axil_bresp;
	logic        s_axil_bvalid;
	logic        s_axil_bready;
	logic [7:0]  s_axil_araddr;
	logic        s_axil_arvalid;
	logic        s_axil_arready;
	logic [31:0] s_axil_rdata;
	logic [1:0]  s_axil_rresp;
	logic        s_axil_rvalid;
	logic        s_axil_rready;
	logic        pix_we;
	pix_addr_t   pix_addr;
	pixel_t      pix_data;
	logic        data_user;
	logic        tx_valid;
	byte_t       tx_data;
	logic        tx_last;
	logic        tx_ready;
	logic [1:0]  exp_seg;
	logic        exp_first;
	logic        arm;
	int          nbytes;
	int          errors;
	int unsigned ready_pct;
	row_t        rows [NUM_ROWS];
	logic [31:0] rd;
	int          exp_start;
	int          errs_before;
	int          fail_rows;
	int          wait_cnt;
	int          assert_fails;

	always #4 clk125MHz = ~clk125MHz;

	always @(posedge clk125MHz) begin
		tx_ready <= ($urandom_range(99) < ready_pct);
	end

	frame_tx_top u_dut (.*);

	frame_tx_checker u_chk (
		.clk125MHz (clk125MHz), .rst_n (rst_n),
		.pix_we (pix_we), .pix_addr (pix_addr), .pix_data (pix_data),
		.tx_valid (tx_valid), .tx_data (tx_data), .tx_last (tx_last), .tx_ready (tx_ready),
		.seg (exp_seg), .first (exp_first), .arm (arm),
		.nbytes (nbytes), .errors (errors)
	);

	bind byte_stream frame_tx_assert u_stream_assert (
		.clk125MHz (clk125MHz), .rst_n (rst_n), .valid (tx_valid), .data (tx_data),
		.last (tx_last), .ready (tx_ready), .bvalid (1'b0), .bready (1'b0)
	);

	bind axil_regs frame_tx_assert u_axil_assert (
		.clk125MHz (clk125MHz), .rst_n (rst_n), .valid (1'b0), .data (8'h00),
		.last (1'b0), .ready (1'b0), .bvalid (s_axil_bvalid), .bready (s_axil_bready)
	);

	task automatic give_up(input string what);
		$display("timeout: no response from the DUT while waiting for %s", what);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		int   cnt;
		logic aw_open;
		logic w_open;
		logic aw_go;
		logic w_go;
		logic b_seen;
		@(posedge clk125MHz);
		s_axil_awaddr  <= addr;
		s_axil_awvalid <= 1'b1;
		s_axil_wdata   <= data;
		s_axil_wvalid  <= 1'b1;
		aw_open = 1'b1;
		w_open  = 1'b1;
		cnt     = 0;
		while (aw_open || w_open) begin
			@(negedge clk125MHz); // sample mid cycle
			aw_go = s_axil_awvalid && s_axil_awready;
			w_go  = s_axil_wvalid && s_axil_wready;
			@(posedge clk125MHz);
			if (aw_go) begin
				s_axil_awvalid <= 1'b0;
				aw_open = 1'b0;
			end
			if (w_go) begin
				s_axil_wvalid <= 1'b0;
				w_open = 1'b0;
			end
			cnt++;
			if (cnt > TIMEOUT) give_up("AXI write address and data");
		end
		b_seen = 1'b0;
		cnt    = 0;
		while (!b_seen) begin
			@(negedge clk125MHz);
			b_seen = s_axil_bvalid;
			if (b_seen) u_chk.check_value("BRESP", int'(s_axil_bresp), 0);
			@(posedge clk125MHz);
			cnt++;
			if (!b_seen && cnt > TIMEOUT) give_up("AXI write response");
		end
		s_axil_bready <= 1'b1; // bvalid has to wait one edge for bready
		@(posedge clk125MHz);
		s_axil_bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		int   cnt;
		logic ar_go;
		logic r_seen;
		@(posedge clk125MHz);
		s_axil_araddr  <= addr;
		s_axil_arvalid <= 1'b1;
		s_axil_rready  <= 1'b1;
		ar_go = 1'b0;
		cnt   = 0;
		while (!ar_go) begin
			@(negedge clk125MHz);
			ar_go = s_axil_arvalid && s_axil_arready;
			@(posedge clk125MHz);
			cnt++;
			if (!ar_go && cnt > TIMEOUT) give_up("AXI read address");
		end
		s_axil_arvalid <= 1'b0;
		r_seen = 1'b0;
		cnt    = 0;
		data   = '0;
		while (!r_seen) begin
			@(negedge clk125MHz);
			r_seen = s_axil_rvalid;
			data   = s_axil_rdata;
			if (r_seen) u_chk.check_value("RRESP", int'(s_axil_rresp), 0);
			@(posedge clk125MHz);
			cnt++;
			if (!r_seen && cnt > TIMEOUT) give_up("AXI read data");
		end
		s_axil_rready <= 1'b0;
	endtask

	task automatic fill_pixels();
		for (int i = 0; i < `VTX_VRAM_DEPTH; i++) begin
			@(posedge clk125MHz);
			pix_we   <= 1'b1;
			pix_addr <= pix_addr_t'(i);
			pix_data <= pixel_t'(24'($urandom));
		end
		@(posedge clk125MHz);
		pix_we <= 1'b0;
	endtask

	// falling edge needs 2 cycles to be seen, startaddr updates on the next
	task automatic pulse_data_user();
		@(posedge clk125MHz);
		data_user <= 1'b1;
		repeat (3) @(posedge clk125MHz);
		data_user <= 1'b0;
		repeat (5) @(posedge clk125MHz);
	endtask

	initial begin
		void'($urandom(32'hd7d06784));
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		pix_we         = 1'b0;
		pix_addr       = '0;
		pix_data       = '0;
		data_user      = 1'b0;
		tx_ready       = 1'b0;
		ready_pct      = 100;
		exp_seg        = '0;
		exp_first      = 1'b0;
		arm            = 1'b0;
		exp_start      = 0;
		fail_rows      = 0;
		rst_n          = 1'b0;

		// txid, segment, redundancy, lastaddr, data_user, ready %, new pixels
		rows[0] = '{1, 0, 0, 24'h000123, 0, 100, 0};
		rows[1] = '{1, 1, 5, 24'h00a5a5, 0, 50, 0};
		rows[2] = '{1, 2, 1, 24'h123456, 1, 100, 0};
		rows[3] = '{1, 3, 2, 24'h0f0f0f, 1, 30, 0};
		rows[4] = '{2, 0, 2, 24'h654321, 1, 60, 1};
		rows[5] = '{2, 2, 7, 24'h111111, 0, 100, 0};
		rows[6] = '{3, 1, 4, 24'h222222, 1, 40, 0};
		rows[7] = '{3, 3, 3, 24'habcdef, 1, 100, 0};
		rows[8] = '{1, 0, 0, 24'h333333, 0, 100, 0};
		rows[9] = '{4, 0, 9, 24'h444444, 0, 25, 0};

		repeat (2) @(posedge clk125MHz);
		rst_n <= 1'b1;
		fill_pixels();

		for (int r = 0; r < NUM_ROWS; r++) begin
			errs_before = errors;
			if (rows[r].new_pix != 0) fill_pixels();
			ready_pct = rows[r].ready_pct;
			axi_write(`VTX_REG_TXID, 32'(rows[r].txid));
			axi_write(`VTX_REG_SEGMENT, 32'(rows[r].seg));
			axi_write(`VTX_REG_REDUNDANCY, 32'(rows[r].red));
			axi_write(`VTX_REG_LASTADDR, 32'(rows[r].last));
			if (rows[r].du != 0) begin
				pulse_data_user();
				if (rows[r].txid == rows[r].red) exp_start = rows[r].last;
			end
			axi_read(`VTX_REG_STARTADDR, rd);
			u_chk.check_value("STARTADDR", int'(rd), exp_start);

			@(posedge clk125MHz);
			exp_seg   <= 2'(rows[r].seg);
			exp_first <= (rows[r].txid == 1);
			arm       <= 1'b1;
			@(posedge clk125MHz);
			arm <= 1'b0;

			axi_write(`VTX_REG_CTRL, 32'd1);
			axi_read(`VTX_REG_STATUS, rd);
			u_chk.check_value("STATUS busy during segment", int'(rd), 1);
			axi_write(`VTX_REG_CTRL, 32'd1); // must be ignored while busy

			wait_cnt = 0;
			while (nbytes < `VTX_SEG_LEN) begin
				@(negedge clk125MHz);
				wait_cnt++;
				if (wait_cnt > 20 * TIMEOUT) give_up("the 16 bytes of a segment");
			end
			repeat (8) @(posedge clk125MHz);
			u_chk.check_value("bytes in segment", nbytes, `VTX_SEG_LEN);
			axi_read(`VTX_REG_STATUS, rd);
			u_chk.check_value("STATUS busy after tx_last", int'(rd), 0);

			if (errors != errs_before) fail_rows++;
			$display("row %0d txid %0d segment %0d ready %0d%%: %s", r, rows[r].txid,
				rows[r].seg, rows[r].ready_pct, (errors == errs_before) ? "ok" : "failed");
		end

		assert_fails = u_dut.u_stream.u_stream_assert.fail_cnt +
			u_dut.u_regs.u_axil_assert.fail_cnt;
		$display("rows %0d, failing rows %0d, errors %0d, assertion failures %0d", NUM_ROWS,
			fail_rows, errors, assert_fails);
		if (errors == 0 && fail_rows == 0 && assert_fails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
